// ==== sim.f ====
src/lb_pkg.sv
src/lb_if.sv
src/lb_write_regs.sv
src/led_pwm.sv
src/dac_spi.sv
src/freq_count.sv
src/lb_slave.sv
test/lb_slave_chk.sv
test/lb_slave_tb.sv

// ==== src/dac_spi.sv ====
`timescale 1ns/10ps

module dac_spi (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic send,
	input logic [lb_pkg::DAC_NCH+15:0] word,
	output logic busy,
	output logic sclk,
	output logic sdo,
	output logic [lb_pkg::DAC_NCH-1:0] sync
);
	import lb_pkg::*;

	logic [DAC_FRAME-1:0] shreg;
	// Two ticks per bit, one for each sclk edge
	logic [$clog2(2*DAC_FRAME)-1:0] tick_cnt;
	logic last_tick;

	// Final falling edge of the frame
	assign last_tick = tick && (tick_cnt == 2*DAC_FRAME-1);

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			sclk <= 1'b0;
			sdo <= 1'b0;
			sync <= '1;
			tick_cnt <= '0;
		end else if (!busy) begin
			// Send pulses while busy are dropped
			if (send) begin
				busy <= 1'b1;
				sclk <= 1'b0;
				tick_cnt <= '0;
				// Selected channels pull their sync low
				sync <= ~word[DAC_NCH+15:16];
			end
		end else if (tick) begin
			sclk <= ~sclk;
			tick_cnt <= tick_cnt + 1'b1;
			// Rising edge presents the next bit
			if (!sclk) begin
				sdo <= shreg[DAC_FRAME-1];
			end
			if (last_tick) begin
				busy <= 1'b0;
				sync <= '1;
			end
		end
	end

	// Frame payload, shifted MSB first
	always_ff @(posedge clk) begin
		if (!busy && send) begin
			// Six don't-care zeros, normal power mode, then the sample
			shreg <= {6'b000000, 2'b00, word[15:0]};
		end else if (busy && tick && !sclk) begin
			shreg <= {shreg[DAC_FRAME-2:0], 1'b0};
		end
	end

endmodule

// ==== src/freq_count.sv ====
`timescale 1ns/10ps

module freq_count (
	input logic clk,
	input logic reset,
	input logic f_in,
	output logic [lb_pkg::FREQ_W-1:0] frequency
);
	import lb_pkg::*;

	logic [1:0] rst_f;
	logic [FREQ_W-1:0] bin_f;
	logic [FREQ_W-1:0] bin_next;
	logic [FREQ_W-1:0] gray_f;
	logic [FREQ_W-1:0] gray_s1;
	logic [FREQ_W-1:0] gray_s2;
	logic [FREQ_W-1:0] count_now;
	logic [FREQ_W-1:0] count_prev;
	logic [FREQ_REF_W-1:0] ref_cnt;

	function automatic logic [FREQ_W-1:0] gray_to_bin(input logic [FREQ_W-1:0] g);
		logic [FREQ_W-1:0] b;
		b[FREQ_W-1] = g[FREQ_W-1];
		for (int i = FREQ_W-2; i >= 0; i--) begin
			b[i] = b[i+1] ^ g[i];
		end
		return b;
	endfunction

	// Reset reaches the edge counter over its own first f_in edges
	always_ff @(posedge f_in) begin
		rst_f <= {rst_f[0], reset};
	end

	assign bin_next = bin_f + 1'b1;

	// Edge counter, Gray coded so only one bit moves per edge
	always_ff @(posedge f_in) begin
		if (rst_f[1]) begin
			bin_f <= '0;
			gray_f <= '0;
		end else begin
			bin_f <= bin_next;
			gray_f <= bin_next ^ (bin_next >> 1);
		end
	end

	// Two-flop crossing into clk
	always_ff @(posedge clk) begin
		gray_s1 <= gray_f;
		gray_s2 <= gray_s1;
	end

	assign count_now = gray_to_bin(gray_s2);

	// Edges seen per reference window
	always_ff @(posedge clk) begin
		if (reset) begin
			ref_cnt <= '0;
			count_prev <= '0;
			frequency <= '0;
		end else begin
			ref_cnt <= ref_cnt + 1'b1;
			if (&ref_cnt) begin
				frequency <= count_now - count_prev;
				count_prev <= count_now;
			end
		end
	end

endmodule

// ==== src/lb_if.sv ====
`timescale 1ns/10ps

// Request half of the local bus
// Read data goes back on a plain port, so it is not part of this bundle
interface lb_if;
	import lb_pkg::*;

	logic [LB_AW-1:0] addr;
	// One-cycle strobe qualifies every transfer
	logic strobe;
	// High for a read, low for a write
	logic rd;
	logic [LB_DW-1:0] wdata;

	// Bus master side
	modport host (
		output addr,
		output strobe,
		output rd,
		output wdata
	);

	// Register block side
	modport target (
		input addr,
		input strobe,
		input rd,
		input wdata
	);

endinterface

// ==== src/lb_pkg.sv ====
package lb_pkg;

	// Local bus widths
	localparam int LB_AW = 24;
	localparam int LB_DW = 32;

	// Page select lives in the upper address byte
	localparam logic [7:0] PAGE_STATUS = 8'h00;
	localparam logic [7:0] PAGE_RX_MAC = 8'h03;
	localparam logic [7:0] PAGE_CTRL = 8'h05;

	// Identity words, read back as plain ASCII
	localparam logic [LB_DW-1:0] HELLO_0 = "Hell";
	localparam logic [LB_DW-1:0] HELLO_1 = "o wo";
	localparam logic [LB_DW-1:0] HELLO_2 = "rld!";
	localparam logic [LB_DW-1:0] HELLO_3 = "(::)";
	// Filler for unused status offsets and unmapped pages
	localparam logic [LB_DW-1:0] FILL_BANK = "zzzz";
	localparam logic [LB_DW-1:0] FILL_BUS = 32'hdeadbeef;

	// Mirror memory, 32 words
	localparam int MIRROR_AW = 5;

	// Control page offsets, low five address bits
	localparam logic [MIRROR_AW-1:0] CTRL_LED_USER = 5'd1;
	localparam logic [MIRROR_AW-1:0] CTRL_LED1 = 5'd2;
	localparam logic [MIRROR_AW-1:0] CTRL_LED2 = 5'd3;
	localparam logic [MIRROR_AW-1:0] CTRL_RX_HBANK = 5'd5;
	localparam logic [MIRROR_AW-1:0] CTRL_MISC = 5'd8;
	localparam logic [MIRROR_AW-1:0] CTRL_DAC = 5'd9;
	localparam logic [MIRROR_AW-1:0] CTRL_FMC0 = 5'd16;
	localparam logic [MIRROR_AW-1:0] CTRL_FMC1 = 5'd17;
	localparam logic [MIRROR_AW-1:0] CTRL_FMC2 = 5'd18;
	localparam logic [MIRROR_AW-1:0] CTRL_FMC3 = 5'd19;
	localparam logic [MIRROR_AW-1:0] CTRL_FMC4 = 5'd20;
	localparam logic [MIRROR_AW-1:0] CTRL_FMC5 = 5'd21;

	// Test pattern, six slices of 22 bits
	localparam int FMC_W = 132;

	// Timing and counter widths
	localparam int LED_CW = 10;
	localparam int FREQ_REF_W = 12;
	localparam int FREQ_W = 32;
	localparam int DAC_NCH = 2;
	localparam int DAC_FRAME = 24;

endpackage

// ==== src/lb_slave.sv ====
`timescale 1ns/10ps

module lb_slave (
	input logic clk,
	input logic reset,
	input logic [lb_pkg::LB_AW-1:0] addr,
	input logic control_strobe,
	input logic control_rd,
	input logic [lb_pkg::LB_DW-1:0] data_out,
	output logic [lb_pkg::LB_DW-1:0] data_in,
	input logic ibadge_clk,
	input logic xdomain_fault,
	input logic tx_mac_done,
	input logic [15:0] rx_mac_data,
	input logic [1:0] rx_mac_buf_status,
	output logic rx_mac_hbank,
	output logic cfg_d02,
	output logic mmc_int,
	output logic allow_mmc_eth_config,
	output logic zest_pwr_en,
	output logic wr_dac_sclk,
	output logic wr_dac_sdo,
	output logic [lb_pkg::DAC_NCH-1:0] wr_dac_sync,
	output logic [lb_pkg::FMC_W-1:0] fmc_test,
	output logic led_user_mode,
	output logic led1,
	output logic led2
);
	import lb_pkg::*;

	logic do_rd;
	logic do_rd_r;
	logic [LB_AW-1:0] addr_r;
	logic [LB_DW-1:0] reg_bank;
	logic [LB_DW-1:0] mirror_data;
	logic [15:0] fault_cnt;
	logic [31:0] uptime;
	logic tx_mac_done_r;
	logic [1:0] rx_mac_buf_status_r;
	logic [FREQ_W-1:0] freq;
	logic [LED_CW-3:0] led1_duty;
	logic [LED_CW-3:0] led2_duty;
	logic [3:0] misc_config;
	logic uptime_tick;
	logic dac_tick;
	logic dac_send;
	logic [DAC_NCH+15:0] dac_word;
	logic dac_busy;

	// Bundle the request side for the register block
	lb_if bus ();
	assign bus.addr = addr;
	assign bus.strobe = control_strobe;
	assign bus.rd = control_rd;
	assign bus.wdata = data_out;

	assign do_rd = control_strobe & control_rd;

	lb_write_regs u_regs (
		.clk(clk),
		.reset(reset),
		.bus(bus),
		.mirror_addr(addr[MIRROR_AW-1:0]),
		.mirror_data(mirror_data),
		.led_user(led_user_mode),
		.led1_duty(led1_duty),
		.led2_duty(led2_duty),
		.rx_hbank(rx_mac_hbank),
		.misc_config(misc_config),
		.fmc_test(fmc_test),
		.dac_send(dac_send),
		.dac_word(dac_word)
	);

	led_pwm u_pwm (
		.clk(clk),
		.reset(reset),
		.led1_duty(led1_duty),
		.led2_duty(led2_duty),
		.led1(led1),
		.led2(led2),
		.uptime_tick(uptime_tick),
		.dac_tick(dac_tick)
	);

	dac_spi u_dac (
		.clk(clk),
		.reset(reset),
		.tick(dac_tick),
		.send(dac_send),
		.word(dac_word),
		.busy(dac_busy),
		.sclk(wr_dac_sclk),
		.sdo(wr_dac_sdo),
		.sync(wr_dac_sync)
	);

	// Measures the badge clock against clk
	freq_count u_freq (
		.clk(clk),
		.reset(reset),
		.f_in(ibadge_clk),
		.frequency(freq)
	);

	// Fault counter, counts clocks with the flag up
	// Uptime advances once per PWM wrap
	always_ff @(posedge clk) begin
		if (reset) begin
			fault_cnt <= '0;
			uptime <= '0;
			tx_mac_done_r <= 1'b0;
			rx_mac_buf_status_r <= '0;
		end else begin
			if (xdomain_fault) begin
				fault_cnt <= fault_cnt + 1'b1;
			end
			if (uptime_tick) begin
				uptime <= uptime + 1'b1;
			end
			// Pin MAC status into clk before it reaches the read mux
			tx_mac_done_r <= tx_mac_done;
			rx_mac_buf_status_r <= rx_mac_buf_status;
		end
	end

	// First read stage, captured at the strobe edge
	always_ff @(posedge clk) begin
		addr_r <= addr;
		if (do_rd) begin
			case (addr[3:0])
				4'd0: reg_bank <= HELLO_0;
				4'd1: reg_bank <= HELLO_1;
				4'd2: reg_bank <= HELLO_2;
				4'd3: reg_bank <= HELLO_3;
				4'd4: reg_bank <= {{(LB_DW-16){1'b0}}, fault_cnt};
				4'd5: reg_bank <= freq;
				4'd6: reg_bank <= {{(LB_DW-1){1'b0}}, tx_mac_done_r};
				4'd7: reg_bank <= {{(LB_DW-2){1'b0}}, rx_mac_buf_status_r};
				4'd8: reg_bank <= uptime;
				4'd9: reg_bank <= {{(LB_DW-1){1'b0}}, dac_busy};
				default: reg_bank <= FILL_BANK;
			endcase
		end
	end

	// Second read stage picks the page
	// data_in then holds until the next read
	always_ff @(posedge clk) begin
		if (reset) begin
			do_rd_r <= 1'b0;
			data_in <= '0;
		end else begin
			do_rd_r <= do_rd;
			if (do_rd_r) begin
				case (addr_r[LB_AW-1:LB_AW-8])
					PAGE_STATUS: data_in <= reg_bank;
					PAGE_RX_MAC: data_in <= {{(LB_DW-16){1'b0}}, rx_mac_data};
					PAGE_CTRL: data_in <= mirror_data;
					default: data_in <= FILL_BUS;
				endcase
			end
		end
	end

	// Misc board controls, one bit each
	assign cfg_d02 = misc_config[0];
	assign mmc_int = misc_config[1];
	assign allow_mmc_eth_config = misc_config[2];
	assign zest_pwr_en = misc_config[3];

endmodule

// ==== src/lb_write_regs.sv ====
`timescale 1ns/10ps

module lb_write_regs (
	input logic clk,
	input logic reset,
	lb_if.target bus,
	input logic [lb_pkg::MIRROR_AW-1:0] mirror_addr,
	output logic [lb_pkg::LB_DW-1:0] mirror_data,
	output logic led_user,
	output logic [lb_pkg::LED_CW-3:0] led1_duty,
	output logic [lb_pkg::LED_CW-3:0] led2_duty,
	output logic rx_hbank,
	output logic [3:0] misc_config,
	output logic [lb_pkg::FMC_W-1:0] fmc_test,
	output logic dac_send,
	output logic [lb_pkg::DAC_NCH+15:0] dac_word
);
	import lb_pkg::*;

	logic local_write;
	logic [MIRROR_AW-1:0] offset;
	logic [LB_DW-1:0] mem [2**MIRROR_AW];

	// Any write strobe aimed at the control page
	assign local_write = bus.strobe & ~bus.rd & (bus.addr[LB_AW-1:LB_AW-8] == PAGE_CTRL);
	// Register select and mirror index share the low address bits
	assign offset = bus.addr[MIRROR_AW-1:0];

	// Control registers
	always_ff @(posedge clk) begin
		if (reset) begin
			led_user <= 1'b0;
			led1_duty <= '0;
			led2_duty <= '0;
			// Receive MAC starts on the high bank
			rx_hbank <= 1'b1;
			misc_config <= '0;
			fmc_test <= '0;
		end else if (local_write) begin
			case (offset)
				CTRL_LED_USER: led_user <= bus.wdata[0];
				CTRL_LED1: led1_duty <= bus.wdata[LED_CW-3:0];
				CTRL_LED2: led2_duty <= bus.wdata[LED_CW-3:0];
				CTRL_RX_HBANK: rx_hbank <= bus.wdata[0];
				CTRL_MISC: misc_config <= bus.wdata[3:0];
				// Test pattern filled one 22-bit slice per offset
				CTRL_FMC0: fmc_test[0*(FMC_W/6) +: FMC_W/6] <= bus.wdata[FMC_W/6-1:0];
				CTRL_FMC1: fmc_test[1*(FMC_W/6) +: FMC_W/6] <= bus.wdata[FMC_W/6-1:0];
				CTRL_FMC2: fmc_test[2*(FMC_W/6) +: FMC_W/6] <= bus.wdata[FMC_W/6-1:0];
				CTRL_FMC3: fmc_test[3*(FMC_W/6) +: FMC_W/6] <= bus.wdata[FMC_W/6-1:0];
				CTRL_FMC4: fmc_test[4*(FMC_W/6) +: FMC_W/6] <= bus.wdata[FMC_W/6-1:0];
				CTRL_FMC5: fmc_test[5*(FMC_W/6) +: FMC_W/6] <= bus.wdata[FMC_W/6-1:0];
				default: ;
			endcase
		end
	end

	// DAC send pulse lands one cycle after the write
	always_ff @(posedge clk) begin
		if (reset) begin
			dac_send <= 1'b0;
		end else begin
			dac_send <= local_write && (offset == CTRL_DAC);
		end
	end

	// Channel selects in the top two bits, sample below
	always_ff @(posedge clk) begin
		if (local_write && (offset == CTRL_DAC)) begin
			dac_word <= bus.wdata[DAC_NCH+15:0];
		end
	end

	// Mirror keeps every control write, whatever the offset
	always_ff @(posedge clk) begin
		if (local_write) begin
			mem[offset] <= bus.wdata;
		end
	end

	// Synchronous readback, sampled by the first read stage
	// A write one edge earlier is already in the array here
	always_ff @(posedge clk) begin
		mirror_data <= mem[mirror_addr];
	end

endmodule

// ==== src/led_pwm.sv ====
`timescale 1ns/10ps

module led_pwm (
	input logic clk,
	input logic reset,
	input logic [lb_pkg::LED_CW-3:0] led1_duty,
	input logic [lb_pkg::LED_CW-3:0] led2_duty,
	output logic led1,
	output logic led2,
	output logic uptime_tick,
	output logic dac_tick
);
	import lb_pkg::*;

	logic [LED_CW-1:0] cnt;

	// Free-running counter
	// Carry out of the top bit becomes the wrap strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
			uptime_tick <= 1'b0;
		end else begin
			{uptime_tick, cnt} <= cnt + 1'b1;
		end
	end

	// Quarter-rate strobe for the DAC serializer
	always_ff @(posedge clk) begin
		if (reset) begin
			dac_tick <= 1'b0;
		end else begin
			dac_tick <= &cnt[1:0];
		end
	end

	// Duty compare, four clocks per duty step
	// Fast enough that the eye only sees brightness
	always_ff @(posedge clk) begin
		if (reset) begin
			led1 <= 1'b0;
			led2 <= 1'b0;
		end else begin
			led1 <= cnt < {led1_duty, 2'b00};
			led2 <= cnt < {led2_duty, 2'b00};
		end
	end

endmodule

// ==== test/lb_slave_chk.sv ====
`timescale 1ns/10ps

module lb_slave_chk (
	input logic clk,
	input logic reset,
	input logic control_strobe,
	input logic control_rd,
	input logic [lb_pkg::LB_DW-1:0] data_in,
	input logic busy,
	input logic sclk,
	input logic [lb_pkg::DAC_NCH-1:0] sync
);

	// Assertion failures so far
	int n_fail = 0;

	// Read data moves only two edges after a read strobe
	a_read_latency: assert property (@(posedge clk) disable iff (reset)
		!$stable(data_in) |-> $past(control_strobe && control_rd, 2))
		else begin
			n_fail++;
			$error("data_in changed without a read strobe two cycles earlier");
		end

	// Serial clock is quiet between frames
	a_sclk_busy: assert property (@(posedge clk) disable iff (reset)
		!$stable(sclk) |-> $past(busy))
		else begin
			n_fail++;
			$error("DAC sclk toggled while the serializer was idle");
		end

	// No channel selected outside a frame
	a_sync_idle: assert property (@(posedge clk) disable iff (reset)
		!busy |-> (sync == '1))
		else begin
			n_fail++;
			$error("DAC sync line low while the serializer was idle");
		end

endmodule

// Attach to every lb_slave instance
bind lb_slave lb_slave_chk u_chk (
	.clk(clk),
	.reset(reset),
	.control_strobe(control_strobe),
	.control_rd(control_rd),
	.data_in(data_in),
	.busy(dac_busy),
	.sclk(wr_dac_sclk),
	.sync(wr_dac_sync)
);

// ==== test/lb_slave_tb.sv ====
`timescale 1ns/10ps

module lb_slave_tb;
	import lb_pkg::*;

	// Longest run is about 13,500 clocks, most of it waiting for frequency windows
	localparam int WATCHDOG_CYCLES = 60000;
	// Expected edges of a 130 ns clock in a 4096-clock window, scaled by 130
	localparam longint FREQ_NOM_X130 = 64'd409600;

	logic clk;
	logic reset;
	logic [LB_AW-1:0] addr;
	logic control_strobe;
	logic control_rd;
	logic [LB_DW-1:0] data_out;
	logic [LB_DW-1:0] data_in;
	logic ibadge_clk;
	logic xdomain_fault;
	logic tx_mac_done;
	logic [15:0] rx_mac_data;
	logic [1:0] rx_mac_buf_status;
	logic rx_mac_hbank;
	logic cfg_d02;
	logic mmc_int;
	logic allow_mmc_eth_config;
	logic zest_pwr_en;
	logic wr_dac_sclk;
	logic wr_dac_sdo;
	logic [DAC_NCH-1:0] wr_dac_sync;
	logic [FMC_W-1:0] fmc_test;
	logic led_user_mode;
	logic led1;
	logic led2;

	integer seed = 32'hf66b_c700;
	int errors = 0;
	int n_checks = 0;
	int cyc = 0;
	// Model of the page map
	logic [LB_DW-1:0] mirror_m [32];
	int fault_m = 0;
	logic busy_m = 1'b0;
	// Reads in flight and their results, in issue order
	logic [LB_DW-1:0] exp_q [$];
	string name_q [$];
	bit chk_q [$];
	logic [LB_DW-1:0] got_q [$];
	int n_issued = 0;
	int n_done = 0;

	lb_slave u_dut (.*);

	always #50 clk = ~clk;
	// Badge clock, unrelated to clk
	always #65 ibadge_clk = ~ibadge_clk;
	always @(posedge clk) cyc <= cyc + 1;

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
		n_checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s: expected %h, got %h", name, exp, got);
		end
	endtask

	// Expected read word for an address, from the page map
	function automatic logic [31:0] ref_read(input logic [LB_AW-1:0] a);
		if (a[23:16] == 8'h00) begin
			case (a[3:0])
				4'd0: return "Hell";
				4'd1: return "o wo";
				4'd2: return "rld!";
				4'd3: return "(::)";
				4'd4: return fault_m;
				4'd6: return {31'b0, tx_mac_done};
				4'd7: return {30'b0, rx_mac_buf_status};
				4'd9: return {31'b0, busy_m};
				// Frequency and uptime are checked by range
				4'd5, 4'd8: return 32'h0;
				default: return "zzzz";
			endcase
		end else if (a[23:16] == 8'h03) begin
			return {16'h0, rx_mac_data};
		end else if (a[23:16] == 8'h05) begin
			return mirror_m[a[4:0]];
		end
		return 32'hdeadbeef;
	endfunction

	// Comparing process, data_in is sampled two edges after the strobe
	initial begin : compare
		logic s1;
		logic s2;
		int idx;
		s1 = 1'b0;
		s2 = 1'b0;
		forever begin
			@(posedge clk);
			s2 = s1;
			s1 = control_strobe & control_rd;
			@(negedge clk);
			if (s2) begin
				idx = n_done;
				got_q.push_back(data_in);
				if (chk_q[idx]) begin
					check(name_q[idx], exp_q[idx], data_in);
				end
				n_done++;
			end
		end
	end

	// Strobe held high by consecutive calls for back-to-back reads
	task automatic issue_read(input logic [LB_AW-1:0] a, input string name, input bit chk);
		@(negedge clk);
		addr = a;
		control_strobe = 1'b1;
		control_rd = 1'b1;
		exp_q.push_back(ref_read(a));
		name_q.push_back(name);
		chk_q.push_back(chk);
		n_issued++;
	endtask

	task automatic bus_idle();
		@(negedge clk);
		control_strobe = 1'b0;
		control_rd = 1'b0;
	endtask

	task automatic wait_reads(output logic [31:0] last);
		bus_idle();
		wait (n_done == n_issued);
		last = got_q[n_done-1];
	endtask

	task automatic bus_write(input logic [LB_AW-1:0] a, input logic [31:0] d);
		@(negedge clk);
		addr = a;
		data_out = d;
		control_strobe = 1'b1;
		control_rd = 1'b0;
		if (a[23:16] == 8'h05) begin
			mirror_m[a[4:0]] = d;
		end
		@(negedge clk);
		control_strobe = 1'b0;
	endtask

	task automatic map_reads();
		logic [31:0] last;
		for (int i = 0; i < 16; i++) begin
			if (i != 5 && i != 8) begin
				issue_read({PAGE_STATUS, 16'(i)}, $sformatf("status offset %0d", i), 1'b1);
			end
		end
		issue_read({PAGE_RX_MAC, 16'h0004}, "rx mac data", 1'b1);
		issue_read(24'h120007, "unmapped page", 1'b1);
		wait_reads(last);
	endtask

	task automatic control_page();
		logic [31:0] last;
		for (int i = 0; i < 32; i++) begin
			bus_write({PAGE_CTRL, 16'(i)}, $random(seed));
		end
		for (int i = 0; i < 32; i++) begin
			issue_read({PAGE_CTRL, 16'(i)}, $sformatf("mirror offset %0d", i), 1'b1);
		end
		wait_reads(last);
		check("led_user_mode", mirror_m[1][0], led_user_mode);
		check("misc outputs", mirror_m[8][3:0],
			{zest_pwr_en, allow_mmc_eth_config, mmc_int, cfg_d02});
		check("rx_mac_hbank", mirror_m[5][0], rx_mac_hbank);
		for (int k = 0; k < 6; k++) begin
			check($sformatf("fmc_test slice %0d", k), mirror_m[16+k][21:0], fmc_test[k*22 +: 22]);
		end
	endtask

	task automatic counters();
		int n;
		int t;
		logic [31:0] last;
		logic [31:0] step;
		n = 1 + ($random(seed) & 255);
		@(negedge clk);
		xdomain_fault = 1'b1;
		repeat (n) @(negedge clk);
		xdomain_fault = 1'b0;
		fault_m += n;
		issue_read({PAGE_STATUS, 16'd4}, "fault count", 1'b1);
		wait_reads(last);
		// Two uptime strobes exactly t clocks apart
		t = 1500 + ($random(seed) & 2047);
		issue_read({PAGE_STATUS, 16'd8}, "uptime first", 1'b0);
		repeat (t - 1) bus_idle();
		issue_read({PAGE_STATUS, 16'd8}, "uptime second", 1'b0);
		wait_reads(last);
		step = last - got_q[n_done-2];
		check("uptime step", (step == t / 1024 || step == t / 1024 + 1) ? step : t / 1024, step);
	endtask

	task automatic pwm_window(input logic [7:0] d1, input logic [7:0] d2);
		int h1;
		int h2;
		bus_write({PAGE_CTRL, 16'(CTRL_LED1)}, d1);
		bus_write({PAGE_CTRL, 16'(CTRL_LED2)}, d2);
		repeat (4) @(negedge clk);
		h1 = 0;
		h2 = 0;
		// One full counter period
		repeat (1024) begin
			@(negedge clk);
			h1 += led1;
			h2 += led2;
		end
		check($sformatf("led1 high clocks, duty %0d", d1), 4 * d1, h1);
		check($sformatf("led2 high clocks, duty %0d", d2), 4 * d2, h2);
	endtask

	task automatic dac_frame_test();
		logic [1:0] sel;
		logic [15:0] sample;
		logic [23:0] bits;
		logic prev;
		logic [31:0] last;
		int nbits;
		sel = $random(seed);
		if (sel == 2'b00) begin
			sel = 2'b11;
		end
		sample = $random(seed);
		bus_write({PAGE_CTRL, 16'(CTRL_DAC)}, {14'h0, sel, sample});
		nbits = 0;
		bits = '0;
		prev = wr_dac_sclk;
		fork
			begin
				// Data bits taken at sclk falling edges
				repeat (600) begin
					@(negedge clk);
					if (prev && !wr_dac_sclk) begin
						bits = {bits[22:0], wr_dac_sdo};
						nbits++;
					end
					prev = wr_dac_sclk;
				end
			end
			begin
				repeat (30) @(negedge clk);
				check("dac sync during frame", 2'(~sel), wr_dac_sync);
				// Second send lands while busy and must not start a frame
				bus_write({PAGE_CTRL, 16'(CTRL_DAC)}, {14'h0, ~sel, ~sample});
				busy_m = 1'b1;
				issue_read({PAGE_STATUS, 16'd9}, "dac busy in frame", 1'b1);
				wait_reads(last);
				busy_m = 1'b0;
			end
		join
		check("dac sclk falling edges", 24, nbits);
		check("dac frame", {8'h00, 8'h00, sample}, bits);
		issue_read({PAGE_STATUS, 16'd9}, "dac busy after frame", 1'b1);
		wait_reads(last);
		check("dac sync after frame", 2'b11, wr_dac_sync);
	endtask

	task automatic frequency_read();
		logic [31:0] f;
		bit ok;
		// Past three windows so a full window follows reset
		while (cyc < 13000) @(negedge clk);
		issue_read({PAGE_STATUS, 16'd5}, "frequency", 1'b0);
		wait_reads(f);
		ok = (longint'(f) * 130 >= FREQ_NOM_X130 - 260) && (longint'(f) * 130 <= FREQ_NOM_X130 + 260);
		check("frequency", ok ? f : 32'd3151, f);
	endtask

	initial begin
		clk = 1'b0;
		ibadge_clk = 1'b0;
		reset = 1'b1;
		addr = '0;
		control_strobe = 1'b0;
		control_rd = 1'b0;
		data_out = '0;
		xdomain_fault = 1'b0;
		tx_mac_done = $random(seed);
		rx_mac_data = $random(seed);
		rx_mac_buf_status = $random(seed);
		repeat (10) @(negedge clk);
		reset = 1'b0;
		check("rx_mac_hbank after reset", 1, rx_mac_hbank);
		check("dac sync after reset", 2'b11, wr_dac_sync);
		map_reads();
		control_page();
		counters();
		pwm_window(8'd0, 8'd255);
		pwm_window(8'($random(seed)), 8'($random(seed)));
		pwm_window(8'd255, 8'd0);
		dac_frame_test();
		frequency_read();
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			n_checks, errors, u_dut.u_chk.n_fail);
		if (errors == 0 && u_dut.u_chk.n_fail == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d clocks, the tests did not finish", WATCHDOG_CYCLES);
		$display("TB FAILED");
		$finish;
	end

endmodule
